/* vlog.f */
hdl/sbm_pkg.sv
hdl/msg_buf_if.sv
hdl/msg_assembler.sv
hdl/msg_arbiter.sv
hdl/msg_compliance.sv
hdl/egress_serializer.sv
hdl/sbm_top.sv
dv/sbm_checker.sv
dv/sbm_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLIST      ?= vlog.f
TOP        ?= sbm_tb
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/sbm_tb.sv */
`timescale 1ns/1ps

module sbm_tb
   import sbm_pkg::*;
();

   localparam int MAX_FLITS       = 16;
   localparam int CLK_PERIOD      = 8;
   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 2000;

   // one egress event, flit or error report
   typedef struct packed {
      logic       is_err;
      logic       np;
      logic       eom;
      logic [7:0] data;
   } ev_t;

   logic       clk         = 1'b0;
   logic       rst         = 1'b1;
   logic [7:0] pc_flit     = 8'h00;
   logic       pc_flit_vld = 1'b0;
   logic       pc_eom      = 1'b0;
   logic       pc_rdy;
   logic [7:0] np_flit     = 8'h00;
   logic       np_flit_vld = 1'b0;
   logic       np_eom      = 1'b0;
   logic       np_rdy;
   logic [7:0] out_flit;
   logic       out_vld;
   logic       out_eom;
   logic       out_rdy     = 1'b1;
   logic       err_vld;
   viol_t      err_code;
   logic       err_np;

   // separate streams for payload and back-pressure
   logic [31:0] data_lfsr = 32'hd7b0e8e7;
   logic [31:0] rdy_lfsr  = 32'hd7b0e8e7;
   logic        bp_en     = 1'b0;

   logic [7:0] pc_msg[$];
   logic [7:0] np_msg[$];
   ev_t        exp_q[$];
   string      test_name     = "none";
   int         fail_cnt      = 0;
   int         errs_at_start = 0;
   int         tests_run     = 0;
   int         tests_failed  = 0;

   sbm_top #(.MAX_FLITS(MAX_FLITS)) i_dut (
      .clk         (clk),
      .rst         (rst),
      .pc_flit     (pc_flit),
      .pc_flit_vld (pc_flit_vld),
      .pc_eom      (pc_eom),
      .pc_rdy      (pc_rdy),
      .np_flit     (np_flit),
      .np_flit_vld (np_flit_vld),
      .np_eom      (np_eom),
      .np_rdy      (np_rdy),
      .out_flit    (out_flit),
      .out_vld     (out_vld),
      .out_eom     (out_eom),
      .out_rdy     (out_rdy),
      .err_vld     (err_vld),
      .err_code    (err_code),
      .err_np      (err_np)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ******************************
   // random source
   // ******************************

   // fibonacci, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++) begin
         data_lfsr = lfsr_step(data_lfsr);
         b[i]      = data_lfsr[0];
      end
      return b;
   endfunction

   function automatic logic rdy_bit();
      rdy_lfsr = lfsr_step(rdy_lfsr);
      return rdy_lfsr[0];
   endfunction

   // egress stall pattern
   always @(negedge clk) begin
      if (bp_en) begin
         out_rdy = rdy_bit();
      end else begin
         out_rdy = 1'b1;
      end
   end

   // ******************************
   // scoreboard
   // ******************************
   function automatic string ev_str(input ev_t e);
      string s;
      if (e.is_err) begin
         s = $sformatf("error code %0d np %0b", e.data, e.np);
      end else begin
         s = $sformatf("flit %02h eom %0b", e.data, e.eom);
      end
      return s;
   endfunction

   // own checks plus the bound assertions
   function automatic int total_errors();
      return fail_cnt + i_dut.u_chk.fail_cnt;
   endfunction

   task automatic check_event(input ev_t got);
      ev_t want;
      assert (exp_q.size() != 0) else begin
         $display("test %s: unexpected output, %s", test_name, ev_str(got));
         fail_cnt++;
      end
      if (exp_q.size() != 0) begin
         want = exp_q.pop_front();
         assert (got == want) else begin
            $display("CHECK FAILED %s: expected %s, actual %s",
                     test_name, ev_str(want), ev_str(got));
            fail_cnt++;
         end
      end
   endtask

   task automatic check_value(input string what, input logic [31:0] want,
                              input logic [31:0] got);
      assert (got == want) else begin
         $display("CHECK FAILED %s: %s expected %0h, actual %0h", test_name, what, want, got);
         fail_cnt++;
      end
   endtask

   // error pulse and transfers, sampled before the edge updates
   always @(posedge clk) begin
      ev_t got;
      if (!rst && err_vld) begin
         got.is_err = 1'b1;
         got.np     = err_np;
         got.eom    = 1'b0;
         got.data   = {5'd0, err_code};
         check_event(got);
      end
      if (!rst && out_vld && out_rdy) begin
         got.is_err = 1'b0;
         got.np     = 1'b0;
         got.eom    = out_eom;
         got.data   = out_flit;
         check_event(got);
      end
   end

   // ******************************
   // stimulus
   // ******************************
   task automatic apply_reset();
      rst = 1'b1;
      repeat (2) @(negedge clk);
      rst = 1'b0;
   endtask

   // header fields at fixed flits, rest random
   task automatic build_msg(input logic np, input logic [7:0] op, input logic [7:0] tag,
                            input logic [7:0] addr, input int len, input viol_t code);
      logic [7:0] b;
      ev_t        e;
      if (np) begin
         np_msg.delete();
      end else begin
         pc_msg.delete();
      end
      for (int k = 0; k < len; k++) begin
         if (k == OPCODE_FLIT) begin
            b = op;
         end else if (k == TAG_FLIT) begin
            b = tag;
         end else if (k == ADDR_FLIT) begin
            b = addr;
         end else begin
            b = rand_byte();
         end
         if (np) begin
            np_msg.push_back(b);
         end else begin
            pc_msg.push_back(b);
         end
         // compliant message leaves unchanged
         if (code == VIOL_NONE) begin
            e.is_err = 1'b0;
            e.np     = 1'b0;
            e.eom    = (k == len - 1);
            e.data   = b;
            exp_q.push_back(e);
         end
      end
      // dropped one shows up only as the report
      if (code != VIOL_NONE) begin
         e.is_err = 1'b1;
         e.np     = np;
         e.eom    = 1'b0;
         e.data   = {5'd0, code};
         exp_q.push_back(e);
      end
   endtask

   task automatic send_msg(input logic np);
      int         i;
      int         len;
      logic       ready;
      logic [7:0] b;
      i   = 0;
      len = np ? np_msg.size() : pc_msg.size();
      while (i < len) begin
         @(negedge clk);
         // rdy seen here is what the next rising edge uses
         ready = np ? np_rdy : pc_rdy;
         b     = np ? np_msg[i] : pc_msg[i];
         if (np) begin
            np_flit     = b;
            np_flit_vld = 1'b1;
            np_eom      = (i == len - 1);
         end else begin
            pc_flit     = b;
            pc_flit_vld = 1'b1;
            pc_eom      = (i == len - 1);
         end
         if (ready) begin
            i++;
         end
      end
      @(negedge clk);
      if (np) begin
         np_flit_vld = 1'b0;
         np_eom      = 1'b0;
      end else begin
         pc_flit_vld = 1'b0;
         pc_eom      = 1'b0;
      end
   endtask

   task automatic post_msg(input logic np, input logic [7:0] op, input logic [7:0] tag,
                           input logic [7:0] addr, input int len, input viol_t code);
      build_msg(np, op, tag, addr, len, code);
      send_msg(np);
   endtask

   // all expected events seen, both buffers released
   task automatic wait_drained();
      @(negedge clk);
      while (exp_q.size() != 0 || !pc_rdy || !np_rdy) begin
         @(negedge clk);
      end
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      errs_at_start = total_errors();
      apply_reset();
   endtask

   task automatic end_test();
      int errs;
      wait_drained();
      bp_en = 1'b0;
      errs  = total_errors() - errs_at_start;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %-12s finished with %0d errors", test_name, errs);
   endtask

   // simple, data and mwr on both channels, alternating
   task automatic send_compliant_set();
      post_msg(1'b0, OP_ASSERT_INTA, 8'h85, 8'h00, 4, VIOL_NONE);
      post_msg(1'b1, OP_LTR, 8'h02, 8'h3f, 12, VIOL_NONE);
      post_msg(1'b0, OP_MWR, 8'h40, 8'h10, 12, VIOL_NONE);
      post_msg(1'b1, OP_DEASSERT_PME, 8'h00, 8'h00, 4, VIOL_NONE);
      post_msg(1'b0, OP_PCIE_ERROR, 8'h01, 8'h55, 8, VIOL_NONE);
      // full buffer
      post_msg(1'b1, OP_MWR, 8'h00, 8'hfc, MAX_FLITS, VIOL_NONE);
   endtask

   // ******************************
   // tests
   // ******************************
   initial begin
      logic [7:0] rr_op;
      int         rr_len;
      logic       served_np;
      logic       first_np;

      start_test("reset");
      check_value("out_vld", 32'd0, 32'(out_vld));
      check_value("err_vld", 32'd0, 32'(err_vld));
      check_value("pc_rdy", 32'd1, 32'(pc_rdy));
      check_value("np_rdy", 32'd1, 32'(np_rdy));
      end_test();

      start_test("compliant");
      send_compliant_set();
      end_test();

      // one of each, priority order
      start_test("violations");
      post_msg(1'b0, OP_LTR, 8'h00, 8'h00, 6, VIOL_SIZE);
      post_msg(1'b1, 8'h30, 8'h00, 8'h00, 4, VIOL_OPCODE);
      post_msg(1'b0, OP_ASSERT_INTB, 8'h00, 8'h00, 8, VIOL_SIMPLE_LEN);
      post_msg(1'b1, OP_PM_REQ, 8'h00, 8'h00, 4, VIOL_DATA_LEN);
      post_msg(1'b0, OP_DO_SERR, 8'h08, 8'h00, 4, VIOL_RSVD);
      post_msg(1'b1, OP_CFGWR, 8'h40, 8'h00, 8, VIOL_ADDRMODE);
      post_msg(1'b0, OP_MRD, 8'h00, 8'h02, 8, VIOL_ALIGN);
      end_test();

      // equal lengths, both eoms land on the same edge
      start_test("round_robin");
      // pc wins the first tie after reset
      served_np = 1'b1;
      for (int r = 0; r < 3; r++) begin
         rr_len = 4 + 4 * r;
         if (r == 0) begin
            rr_op = OP_ASSERT_INTC;
         end else begin
            rr_op = OP_PM_RSP;
         end
         // lone pc message makes np the next tie winner
         if (r == 1) begin
            post_msg(1'b0, OP_ASSERT_INTD, 8'h00, 8'h00, 4, VIOL_NONE);
            wait_drained();
            served_np = 1'b0;
         end
         // tie goes to the channel not served last
         first_np = !served_np;
         build_msg(first_np, rr_op, 8'h00, 8'h00, rr_len, VIOL_NONE);
         build_msg(!first_np, rr_op, 8'h00, 8'h00, rr_len, VIOL_NONE);
         fork
            send_msg(1'b0);
            send_msg(1'b1);
         join
         wait_drained();
         served_np = !first_np;
      end
      end_test();

      start_test("backpressure");
      bp_en = 1'b1;
      send_compliant_set();
      end_test();

      start_test("overflow");
      post_msg(1'b1, OP_LTR, 8'h00, 8'h00, MAX_FLITS + 4, VIOL_SIZE);
      post_msg(1'b0, OP_MWR, 8'h00, 8'h00, MAX_FLITS + 1, VIOL_SIZE);
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
               total_errors());
      if (total_errors() == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // budget of cycles for every test
   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("watchdog expired in test %s, simulation did not finish", test_name);
      $display("** FAIL **");
      $finish;
   end

endmodule

/* dv/sbm_checker.sv */
`timescale 1ns/1ps

module sbm_checker (
   input logic       clk,
   input logic       rst,
   input logic [7:0] out_flit,
   input logic       out_vld,
   input logic       out_eom,
   input logic       out_rdy,
   input logic       err_vld
);

   // failed assertions so far, summed into the testbench total
   int fail_cnt = 0;

   // ******************************
   // egress bus
   // ******************************

   // stalled flit stays offered and unchanged
   a_stall_stable: assert property (
      @(posedge clk) disable iff (rst)
      (out_vld && !out_rdy) |=> (out_vld && $stable(out_flit) && $stable(out_eom))
   ) else begin
      $error("egress flit or eom changed while out_rdy was low");
      fail_cnt++;
   end

   // ******************************
   // error report
   // ******************************

   // single cycle pulse
   a_err_pulse: assert property (
      @(posedge clk) disable iff (rst)
      err_vld |=> !err_vld
   ) else begin
      $error("err_vld stayed high for more than one cycle");
      fail_cnt++;
   end

   // dropped message sends nothing
   a_err_no_flit: assert property (
      @(posedge clk) disable iff (rst)
      !(err_vld && out_vld)
   ) else begin
      $error("err_vld and out_vld high in the same cycle");
      fail_cnt++;
   end

   // outputs quiet once reset has been seen
   a_rst_quiet: assert property (
      @(posedge clk)
      rst |=> (!out_vld && !err_vld)
   ) else begin
      $error("out_vld or err_vld high in the cycle after reset");
      fail_cnt++;
   end

endmodule

bind sbm_top sbm_checker u_chk (
   .clk      (clk),
   .rst      (rst),
   .out_flit (out_flit),
   .out_vld  (out_vld),
   .out_eom  (out_eom),
   .out_rdy  (out_rdy),
   .err_vld  (err_vld)
);

/* hdl/sbm_top.sv */
`timescale 1ns/1ps

module sbm_top
   import sbm_pkg::*;
#(
   parameter int MAX_FLITS = 16
) (
   input  logic       clk,
   input  logic       rst,
   // posted producer
   input  logic [7:0] pc_flit,
   input  logic       pc_flit_vld,
   input  logic       pc_eom,
   output logic       pc_rdy,
   // non-posted producer
   input  logic [7:0] np_flit,
   input  logic       np_flit_vld,
   input  logic       np_eom,
   output logic       np_rdy,
   // egress flit bus
   output logic [7:0] out_flit,
   output logic       out_vld,
   output logic       out_eom,
   input  logic       out_rdy,
   // dropped message report
   output logic       err_vld,
   output viol_t      err_code,
   output logic       err_np
);

   localparam int CNT_W = $clog2(MAX_FLITS + 1);

   // granted message, shared side
   logic                      busy;
   logic                      grant_np;
   logic [CNT_W-1:0]          num_flits;
   logic                      ovf;
   logic [MAX_FLITS-1:0][7:0] flits;
   viol_t                     viol;
   logic                      done;

   msg_buf_if #(.MAX_FLITS(MAX_FLITS)) pc_buf_if ();
   msg_buf_if #(.MAX_FLITS(MAX_FLITS)) np_buf_if ();

   // ******************************
   // message buffers
   // ******************************
   msg_assembler #(.MAX_FLITS(MAX_FLITS)) u_pc_asm (
      .clk      (clk),
      .rst      (rst),
      .flit     (pc_flit),
      .flit_vld (pc_flit_vld),
      .eom      (pc_eom),
      .rdy      (pc_rdy),
      .buf_if   (pc_buf_if.owner)
   );

   msg_assembler #(.MAX_FLITS(MAX_FLITS)) u_np_asm (
      .clk      (clk),
      .rst      (rst),
      .flit     (np_flit),
      .flit_vld (np_flit_vld),
      .eom      (np_eom),
      .rdy      (np_rdy),
      .buf_if   (np_buf_if.owner)
   );

   // ******************************
   // arbitration, check, egress
   // ******************************
   msg_arbiter #(.MAX_FLITS(MAX_FLITS)) u_arb (
      .clk       (clk),
      .rst       (rst),
      .pc_if     (pc_buf_if.user),
      .np_if     (np_buf_if.user),
      .done      (done),
      .busy      (busy),
      .grant_np  (grant_np),
      .num_flits (num_flits),
      .ovf       (ovf),
      .flits     (flits)
   );

   msg_compliance #(.MAX_FLITS(MAX_FLITS)) u_comp (
      .num_flits (num_flits),
      .ovf       (ovf),
      .flits     (flits),
      .viol      (viol)
   );

   egress_serializer #(.MAX_FLITS(MAX_FLITS)) u_ser (
      .clk       (clk),
      .rst       (rst),
      .busy      (busy),
      .grant_np  (grant_np),
      .num_flits (num_flits),
      .flits     (flits),
      .viol      (viol),
      .done      (done),
      .out_flit  (out_flit),
      .out_vld   (out_vld),
      .out_eom   (out_eom),
      .out_rdy   (out_rdy),
      .err_vld   (err_vld),
      .err_code  (err_code),
      .err_np    (err_np)
   );

endmodule

/* hdl/egress_serializer.sv */
`timescale 1ns/1ps

module egress_serializer
   import sbm_pkg::*;
#(
   parameter int MAX_FLITS = 16
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             busy,
   input  logic                             grant_np,
   input  logic [$clog2(MAX_FLITS + 1)-1:0] num_flits,
   input  logic [MAX_FLITS-1:0][7:0]        flits,
   input  viol_t                            viol,
   output logic                             done,
   output logic [7:0]                       out_flit,
   output logic                             out_vld,
   output logic                             out_eom,
   input  logic                             out_rdy,
   output logic                             err_vld,
   output viol_t                            err_code,
   output logic                             err_np
);

   localparam int CNT_W = $clog2(MAX_FLITS + 1);
   localparam int IDX_W = $clog2(MAX_FLITS);

   typedef enum logic [1:0] {
      IDLE,
      DECIDE,
      SEND,
      DONE
   } ser_state_t;

   ser_state_t       state;
   logic [CNT_W-1:0] idx;
   logic             pass;
   logic             xfer;
   logic             last;

   assign pass = (viol == VIOL_NONE);
   // flit index of the last one
   assign last = (idx == num_flits - CNT_W'(1));

   // ******************************
   // egress outputs
   // ******************************
   // flit 0 already offered in the decide cycle
   assign out_vld  = ((state == DECIDE) && pass) || (state == SEND);
   assign out_flit = flits[idx[IDX_W-1:0]];
   assign out_eom  = out_vld && last;
   assign xfer     = out_vld && out_rdy;

   // drop path, single pulse
   assign err_vld  = (state == DECIDE) && !pass;
   assign err_code = viol;
   assign err_np   = grant_np;

   // back to the arbiter
   assign done = (state == DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         idx   <= '0;
      end else begin
         case (state)
            IDLE: begin
               idx <= '0;
               if (busy) begin
                  state <= DECIDE;
               end
            end
            DECIDE, SEND: begin
               if (!out_vld) begin
                  // non compliant, nothing sent
                  state <= DONE;
               end else if (xfer && last) begin
                  state <= DONE;
               end else begin
                  state <= SEND;
                  if (xfer) begin
                     idx <= idx + CNT_W'(1);
                  end
               end
            end
            DONE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

/* hdl/msg_compliance.sv */
`timescale 1ns/1ps

module msg_compliance
   import sbm_pkg::*;
#(
   parameter int MAX_FLITS = 16
) (
   input  logic [$clog2(MAX_FLITS + 1)-1:0] num_flits,
   input  logic                             ovf,
   input  logic [MAX_FLITS-1:0][7:0]        flits,
   output viol_t                            viol
);

   localparam int CNT_W = $clog2(MAX_FLITS + 1);

   logic [7:0] opcode;
   logic [7:0] tag;
   logic [7:0] addr;
   msg_class_t cls;

   // one flag per rule
   logic size_bad;
   logic opcode_bad;
   logic simple_len_bad;
   logic data_len_bad;
   logic rsvd_bad;
   logic addrmode_bad;
   logic align_bad;

   // ******************************
   // header fields
   // ******************************
   assign opcode = flits[OPCODE_FLIT];
   assign tag    = flits[TAG_FLIT];
   assign addr   = flits[ADDR_FLIT];
   assign cls    = classify_opcode(opcode);

   // ******************************
   // rules
   // ******************************

   // whole dwords, at least one
   assign size_bad = ovf || (num_flits == '0) || (num_flits[1:0] != 2'b00);

   assign opcode_bad = (cls == CLS_ILLEGAL);

   // simple is header only
   assign simple_len_bad = (cls == CLS_SIMPLE) && (num_flits != CNT_W'(SIMPLE_FLITS));
   // header plus at least one data dword
   assign data_len_bad   = (cls == CLS_DATA) && (num_flits < CNT_W'(DATA_MIN_FLITS));

   // tag reserved bits
   assign rsvd_bad = ((cls == CLS_SIMPLE) || (cls == CLS_DATA)) &&
                     (tag[RSVD_HI:RSVD_LO] != 4'h0);

   // cfg and io only take the short address
   assign addrmode_bad = (opcode inside {OP_CFGRD, OP_CFGWR, OP_IORD, OP_IOWR}) &&
                         tag[ADDRMODE_BIT];

   // mem and io need dword address
   // checked only when the address flit is part of the message
   assign align_bad = (opcode inside {OP_MRD, OP_MWR, OP_IORD, OP_IOWR}) &&
                      (num_flits > CNT_W'(ADDR_FLIT)) &&
                      (addr[1:0] != 2'b00);

   // first failing rule in priority order
   always_comb begin
      if (size_bad) begin
         viol = VIOL_SIZE;
      end else if (opcode_bad) begin
         viol = VIOL_OPCODE;
      end else if (simple_len_bad) begin
         viol = VIOL_SIMPLE_LEN;
      end else if (data_len_bad) begin
         viol = VIOL_DATA_LEN;
      end else if (rsvd_bad) begin
         viol = VIOL_RSVD;
      end else if (addrmode_bad) begin
         viol = VIOL_ADDRMODE;
      end else if (align_bad) begin
         viol = VIOL_ALIGN;
      end else begin
         viol = VIOL_NONE;
      end
   end

endmodule

/* hdl/msg_arbiter.sv */
`timescale 1ns/1ps

module msg_arbiter #(
   parameter int MAX_FLITS = 16
) (
   input  logic                               clk,
   input  logic                               rst,
   msg_buf_if.user                            pc_if,
   msg_buf_if.user                            np_if,
   input  logic                               done,
   output logic                               busy,
   output logic                               grant_np,
   output logic [$clog2(MAX_FLITS + 1)-1:0]   num_flits,
   output logic                               ovf,
   output logic [MAX_FLITS-1:0][7:0]          flits
);

   // channel served most recently, 1 = np
   logic last_np;
   logic pick_np;

   // np wins alone, or when both wait and pc went last
   assign pick_np = np_if.vld && (!pc_if.vld || !last_np);

   // ******************************
   // grant register
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         grant_np <= 1'b0;
         // so that pc goes first
         last_np  <= 1'b1;
      end else if (!busy) begin
         if (pc_if.vld || np_if.vld) begin
            busy     <= 1'b1;
            grant_np <= pick_np;
            last_np  <= pick_np;
         end
      end else if (done) begin
         // grant drops with done
         busy <= 1'b0;
      end
   end

   // granted buffer onto the shared side
   assign num_flits = grant_np ? np_if.num_flits : pc_if.num_flits;
   assign ovf       = grant_np ? np_if.ovf       : pc_if.ovf;
   assign flits     = grant_np ? np_if.flits     : pc_if.flits;

   // done goes back only to the granted owner
   assign pc_if.rel = done && busy && !grant_np;
   assign np_if.rel = done && busy && grant_np;

endmodule

/* hdl/msg_assembler.sv */
`timescale 1ns/1ps

module msg_assembler #(
   parameter int MAX_FLITS = 16
) (
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] flit,
   input  logic       flit_vld,
   input  logic       eom,
   output logic       rdy,
   msg_buf_if.owner   buf_if
);

   localparam int CNT_W = $clog2(MAX_FLITS + 1);
   localparam int IDX_W = $clog2(MAX_FLITS);

   typedef enum logic {
      FILL,
      HOLD
   } asm_state_t;

   asm_state_t                state;
   logic [CNT_W-1:0]          cnt;
   logic                      ovf;
   logic [MAX_FLITS-1:0][7:0] flits;
   logic                      accept;
   logic                      room;

   // producer stalls while a message is held
   assign rdy    = (state == FILL);
   assign accept = flit_vld && rdy;
   // space left for one more flit
   assign room   = (cnt < CNT_W'(MAX_FLITS));

   // ******************************
   // fill / hold control
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= FILL;
         cnt   <= '0;
         ovf   <= 1'b0;
      end else begin
         case (state)
            FILL: begin
               if (accept) begin
                  // count saturates, extra flits only flag overflow
                  if (room) begin
                     cnt <= cnt + CNT_W'(1);
                  end else begin
                     ovf <= 1'b1;
                  end
                  // last flit closes the message
                  if (eom) begin
                     state <= HOLD;
                  end
               end
            end
            HOLD: begin
               // arbiter done with it, start over
               if (buf_if.rel) begin
                  state <= FILL;
                  cnt   <= '0;
                  ovf   <= 1'b0;
               end
            end
            default: begin
               state <= FILL;
            end
         endcase
      end
   end

   // flit storage
   always_ff @(posedge clk) begin
      if (accept && room) begin
         flits[cnt[IDX_W-1:0]] <= flit;
      end
   end

   // held buffer towards the arbiter
   assign buf_if.vld       = (state == HOLD);
   assign buf_if.num_flits = cnt;
   assign buf_if.ovf       = ovf;
   assign buf_if.flits     = flits;

endmodule

/* hdl/msg_buf_if.sv */
`timescale 1ns/1ps

// one held message buffer between an assembler and the arbiter
interface msg_buf_if #(
   parameter int MAX_FLITS = 16
);

   localparam int CNT_W = $clog2(MAX_FLITS + 1);

   // level, message complete and waiting
   logic                      vld;
   logic [CNT_W-1:0]          num_flits;
   // more flits arrived than fit
   logic                      ovf;
   logic [MAX_FLITS-1:0][7:0] flits;
   // single cycle pulse, buffer may refill
   logic                      rel;

   modport owner (
      output vld,
      output num_flits,
      output ovf,
      output flits,
      input  rel
   );

   modport user (
      input  vld,
      input  num_flits,
      input  ovf,
      input  flits,
      output rel
   );

endinterface

/* hdl/sbm_pkg.sv */
package sbm_pkg;

   // ******************************
   // endpoint specific opcode ranges
   // ******************************
   localparam logic [7:0] REG_EP_LO    = 8'h10;
   localparam logic [7:0] REG_EP_HI    = 8'h1f;
   localparam logic [7:0] DATA_EP_LO   = 8'h60;
   localparam logic [7:0] DATA_EP_HI   = 8'h7f;
   localparam logic [7:0] SIMPLE_EP_LO = 8'ha0;
   localparam logic [7:0] SIMPLE_EP_HI = 8'hff;

   // ******************************
   // global opcodes
   // ******************************

   // simple messages, header only
   typedef enum logic [7:0] {
      OP_ASSERT_INTA   = 8'h80,
      OP_ASSERT_INTB   = 8'h81,
      OP_ASSERT_INTC   = 8'h82,
      OP_ASSERT_INTD   = 8'h83,
      OP_DEASSERT_INTA = 8'h84,
      OP_DEASSERT_INTB = 8'h85,
      OP_DEASSERT_INTC = 8'h86,
      OP_DEASSERT_INTD = 8'h87,
      OP_DO_SERR       = 8'h88,
      OP_ASSERT_PME    = 8'h90,
      OP_DEASSERT_PME  = 8'h91
   } simple_opcode_t;

   // messages carrying data
   typedef enum logic [7:0] {
      OP_PM_REQ     = 8'h40,
      OP_PM_DMD     = 8'h41,
      OP_PM_RSP     = 8'h42,
      OP_LTR        = 8'h43,
      OP_DOPME      = 8'h44,
      OP_PCI_PM     = 8'h48,
      OP_PCIE_ERROR = 8'h49
   } data_opcode_t;

   // register accesses, bit 0 set for writes
   typedef enum logic [7:0] {
      OP_MRD   = 8'h00,
      OP_MWR   = 8'h01,
      OP_IORD  = 8'h02,
      OP_IOWR  = 8'h03,
      OP_CFGRD = 8'h04,
      OP_CFGWR = 8'h05,
      OP_CRRD  = 8'h06,
      OP_CRWR  = 8'h07
   } reg_opcode_t;

   // completions
   typedef enum logic [7:0] {
      OP_CMP  = 8'h20,
      OP_CMPD = 8'h21
   } cmp_opcode_t;

   typedef enum logic [2:0] {
      CLS_SIMPLE,
      CLS_DATA,
      CLS_REG,
      CLS_CMP,
      CLS_ILLEGAL
   } msg_class_t;

   // listed in reporting priority, first failing rule wins
   typedef enum logic [2:0] {
      VIOL_NONE,
      VIOL_SIZE,
      VIOL_OPCODE,
      VIOL_SIMPLE_LEN,
      VIOL_DATA_LEN,
      VIOL_RSVD,
      VIOL_ADDRMODE,
      VIOL_ALIGN
   } viol_t;

   // ******************************
   // flit positions and fields
   // ******************************
   localparam int OPCODE_FLIT    = 2;
   localparam int TAG_FLIT       = 3;
   localparam int ADDR_FLIT      = 6;
   // inside the tag flit
   localparam int ADDRMODE_BIT   = 6;
   localparam int RSVD_HI        = 6;
   localparam int RSVD_LO        = 3;
   // length rules
   localparam int SIMPLE_FLITS   = 4;
   localparam int DATA_MIN_FLITS = 8;

   function automatic logic is_simple_op(input logic [7:0] op);
      return op inside {[OP_ASSERT_INTA:OP_DO_SERR], OP_ASSERT_PME, OP_DEASSERT_PME,
                        [SIMPLE_EP_LO:SIMPLE_EP_HI]};
   endfunction

   function automatic logic is_data_op(input logic [7:0] op);
      return op inside {[OP_PM_REQ:OP_DOPME], OP_PCI_PM, OP_PCIE_ERROR,
                        [DATA_EP_LO:DATA_EP_HI]};
   endfunction

   function automatic logic is_reg_op(input logic [7:0] op);
      return op inside {[OP_MRD:OP_CRWR], [REG_EP_LO:REG_EP_HI]};
   endfunction

   function automatic logic is_cmp_op(input logic [7:0] op);
      return op inside {OP_CMP, OP_CMPD};
   endfunction

   function automatic msg_class_t classify_opcode(input logic [7:0] op);
      msg_class_t cls;
      if (is_simple_op(op)) begin
         cls = CLS_SIMPLE;
      end else if (is_data_op(op)) begin
         cls = CLS_DATA;
      end else if (is_reg_op(op)) begin
         cls = CLS_REG;
      end else if (is_cmp_op(op)) begin
         cls = CLS_CMP;
      end else begin
         cls = CLS_ILLEGAL;
      end
      return cls;
   endfunction

endpackage
